// ==== rtl/alu8051_pkg.sv ====
/*
 * Shared types and constants of the 8051-class ALU.
 * Opcode codes not listed in alu_op_e decode as OP_IDLE.
 * PSW layout is {CY, AC, F0, RS1, RS0, OV, reserved, P}.
 */
package alu8051_pkg;

	localparam int BYTE_W    = 8;
	localparam int BIT_IDX_W = 3;
	localparam int MUL_STEPS = 8;
	localparam int DA_LIMIT  = 9;

	// PSW bit positions
	localparam int PSW_CY  = 7;
	localparam int PSW_AC  = 6;
	localparam int PSW_F0  = 5;
	localparam int PSW_RS1 = 4;
	localparam int PSW_RS0 = 3;
	localparam int PSW_OV  = 2;
	localparam int PSW_P   = 0;

	typedef logic [BYTE_W-1:0] byte_t;

	typedef enum logic [4:0] {
		OP_IDLE    = 5'd0,
		OP_ADD     = 5'd1,
		OP_ADDC    = 5'd2,
		OP_SUBB    = 5'd3,
		OP_RR      = 5'd4,
		OP_RL      = 5'd5,
		OP_RRC     = 5'd6,
		OP_RLC     = 5'd7,
		OP_AND     = 5'd8,
		OP_OR      = 5'd9,
		OP_XOR     = 5'd10,
		OP_CPL     = 5'd11,
		OP_SWAP    = 5'd12,
		OP_DA      = 5'd13,
		OP_XCHD    = 5'd14,
		OP_INCDPTR = 5'd15,
		OP_MUL     = 5'd16,
		OP_DIV     = 5'd17,
		// Carry bit operations
		OP_ANLC    = 5'd18,
		OP_ANLNC   = 5'd19,
		OP_ORLC    = 5'd20,
		OP_ORLNC   = 5'd21,
		OP_MOVCB   = 5'd22,
		OP_CLRC    = 5'd23,
		OP_SETBC   = 5'd24,
		OP_CPLC    = 5'd25,
		OP_CJNE    = 5'd26,
		// Bit operations on the bit byte
		OP_CLRB    = 5'd27,
		OP_SETBB   = 5'd28,
		OP_CPLB    = 5'd29,
		OP_MOVBC   = 5'd30
	} alu_op_e;

	typedef enum logic {
		PSW_RELOAD = 1'b0,
		PSW_UPDATE = 1'b1
	} psw_mode_e;

	// One byte seen whole or as two BCD digits
	typedef union packed {
		byte_t byte_v;
		struct packed {
			logic [BYTE_W/2-1:0] hi;
			logic [BYTE_W/2-1:0] lo;
		} nib;
	} nibble_u;

endpackage

// ==== rtl/muldiv_if.sv ====
/*
 * Request/done link between the sequencer and one multi-cycle unit.
 * req and done are single-cycle pulses; a and b hold until done.
 */
`timescale 1ns/1ps
interface muldiv_if ();
	import alu8051_pkg::*;

	logic  req;
	byte_t a;
	byte_t b;
	logic  done;
	byte_t lo;
	byte_t hi;
	logic  ov;

	modport requester (output req, a, b, input done, lo, hi, ov);
	modport unit (input req, a, b, output done, lo, hi, ov);

endinterface

// ==== rtl/alu_combo_unit.sv ====
/*
 * Purely combinational single-cycle ALU operations.
 * SUBB adds the two's complement of b and does not use the carry in.
 * OV is reported as 0 by every opcode other than ADD, ADDC and SUBB.
 */
`timescale 1ns/1ps
module alu_combo_unit (
	input  alu8051_pkg::alu_op_e               i_op,
	input  alu8051_pkg::byte_t                 i_a,
	input  alu8051_pkg::byte_t                 i_b,
	input  alu8051_pkg::byte_t                 i_bit_byte,
	input  logic [alu8051_pkg::BIT_IDX_W-1:0]  i_bit_idx,
	input  logic                               i_cy,
	input  logic                               i_ac,
	output alu8051_pkg::byte_t                 o_lo,
	output alu8051_pkg::byte_t                 o_hi,
	output logic                               o_cy,
	output logic                               o_ac,
	output logic                               o_ov
);
	import alu8051_pkg::*;

	byte_t           b_eff;
	logic            cin;
	logic [4:0]      sum_lo;
	logic [3:0]      sum_mid;
	logic [1:0]      sum_top;
	nibble_u         a_n;
	nibble_u         b_n;
	byte_t           da_adj;
	logic [BYTE_W:0] da_sum;
	logic            bit_val;
	byte_t           bit_mask;

	// Adder split at bit 3 and bit 6 for the AC and OV carries
	assign b_eff   = (i_op == OP_SUBB) ? (~i_b + 8'd1) : i_b;
	assign cin     = (i_op == OP_ADDC) & i_cy;
	assign sum_lo  = {1'b0, i_a[3:0]} + {1'b0, b_eff[3:0]} + {4'd0, cin};
	assign sum_mid = {1'b0, i_a[6:4]} + {1'b0, b_eff[6:4]} + {3'd0, sum_lo[4]};
	assign sum_top = {1'b0, i_a[7]} + {1'b0, b_eff[7]} + {1'b0, sum_mid[3]};

	assign a_n.byte_v = i_a;
	assign b_n.byte_v = i_b;

	// Decimal adjust, both digits judged on the unadjusted value
	assign da_adj = (((a_n.nib.lo > DA_LIMIT) || i_ac) ? 8'h06 : 8'h00)
		| (((a_n.nib.hi > DA_LIMIT) || i_cy) ? 8'h60 : 8'h00);
	assign da_sum = {1'b0, a_n.byte_v} + {1'b0, da_adj};

	assign bit_val  = i_bit_byte[i_bit_idx];
	assign bit_mask = byte_t'(1) << i_bit_idx;

	always_comb
	begin
		// Carry-only opcodes leave the accumulator value on lo
		o_lo = i_a;
		o_hi = '0;
		o_cy = i_cy;
		o_ac = i_ac;
		o_ov = 1'b0;
		case (i_op)
			OP_ADD, OP_ADDC, OP_SUBB:
			begin
				o_lo = {sum_top[0], sum_mid[2:0], sum_lo[3:0]};
				o_cy = sum_top[1];
				o_ac = sum_lo[4];
				o_ov = sum_top[1] ^ sum_mid[3];
			end
			OP_RR:   o_lo = {i_a[0], i_a[7:1]};
			OP_RL:   o_lo = {i_a[6:0], i_a[7]};
			OP_RRC:
			begin
				o_lo = {i_cy, i_a[7:1]};
				o_cy = i_a[0];
			end
			OP_RLC:
			begin
				o_lo = {i_a[6:0], i_cy};
				o_cy = i_a[7];
			end
			OP_AND:  o_lo = i_a & i_b;
			OP_OR:   o_lo = i_a | i_b;
			OP_XOR:  o_lo = i_a ^ i_b;
			OP_CPL:  o_lo = ~i_a;
			OP_SWAP: o_lo = {a_n.nib.lo, a_n.nib.hi};
			OP_DA:
			begin
				o_lo = da_sum[BYTE_W-1:0];
				o_cy = da_sum[BYTE_W] | i_cy;
			end
			// Low digits trade places between the two bytes
			OP_XCHD:
			begin
				o_lo = {a_n.nib.hi, b_n.nib.lo};
				o_hi = {b_n.nib.hi, a_n.nib.lo};
			end
			OP_INCDPTR: {o_hi, o_lo} = {i_b, i_a} + 16'd1;
			OP_ANLC:  o_cy = i_cy & bit_val;
			OP_ANLNC: o_cy = i_cy & ~bit_val;
			OP_ORLC:  o_cy = i_cy | bit_val;
			OP_ORLNC: o_cy = i_cy | ~bit_val;
			OP_MOVCB: o_cy = bit_val;
			OP_CLRC:  o_cy = 1'b0;
			OP_SETBC: o_cy = 1'b1;
			OP_CPLC:  o_cy = ~i_cy;
			OP_CJNE:  o_cy = (i_a < i_b);
			OP_CLRB:  o_lo = i_bit_byte & ~bit_mask;
			OP_SETBB: o_lo = i_bit_byte | bit_mask;
			OP_CPLB:  o_lo = i_bit_byte ^ bit_mask;
			OP_MOVBC: o_lo = i_cy ? (i_bit_byte | bit_mask) : (i_bit_byte & ~bit_mask);
			default: ;
		endcase
	end

endmodule

// ==== rtl/alu_multiplier.sv ====
/*
 * Shift-add 8x8 multiplier, done pulses 9 cycles after req.
 * Operands must stay stable on the interface until done.
 */
`timescale 1ns/1ps
module alu_multiplier (
	input  logic   clk,
	input  logic   reset_n,
	muldiv_if.unit i_md
);
	import alu8051_pkg::*;

	logic                         running_q;
	logic                         done_q;
	logic [$clog2(MUL_STEPS)-1:0] step_q;
	logic                         last_step;
	logic [2*BYTE_W-1:0]          addend;
	logic [2*BYTE_W-1:0]          prod_q;

	assign last_step = (step_q == ($clog2(MUL_STEPS))'(MUL_STEPS - 1));
	// Multiplicand weighted by the current multiplier bit
	assign addend    = (2*BYTE_W)'(i_md.b) << step_q;

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			running_q <= 1'b0;
			done_q    <= 1'b0;
			step_q    <= '0;
		end
		else
		begin
			done_q <= 1'b0;
			if (i_md.req)
			begin
				running_q <= 1'b1;
				step_q    <= '0;
			end
			else if (running_q)
			begin
				step_q <= step_q + 1'b1;
				if (last_step)
				begin
					running_q <= 1'b0;
					done_q    <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (i_md.req)
			prod_q <= '0;
		else if (running_q && i_md.a[step_q])
			prod_q <= prod_q + addend;
	end

	assign i_md.done = done_q;
	assign i_md.lo   = prod_q[BYTE_W-1:0];
	assign i_md.hi   = prod_q[2*BYTE_W-1:BYTE_W];
	assign i_md.ov   = |prod_q[2*BYTE_W-1:BYTE_W];

endmodule

// ==== rtl/alu_divider.sv ====
/*
 * Repeated-subtraction divider, one cycle per quotient count.
 * Divide by zero returns zero quotient and remainder with ov set.
 * Operands must stay stable on the interface until done.
 */
`timescale 1ns/1ps
module alu_divider (
	input  logic   clk,
	input  logic   reset_n,
	muldiv_if.unit i_md
);
	import alu8051_pkg::*;

	logic  running_q;
	logic  done_q;
	logic  ov_q;
	byte_t quot_q;
	byte_t rem_q;
	logic  div_zero;
	logic  can_sub;

	assign div_zero = (i_md.b == '0);
	assign can_sub  = (rem_q >= i_md.b);

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			running_q <= 1'b0;
			done_q    <= 1'b0;
			ov_q      <= 1'b0;
		end
		else
		begin
			done_q <= 1'b0;
			if (i_md.req)
			begin
				running_q <= 1'b1;
				ov_q      <= 1'b0;
			end
			else if (running_q && (div_zero || !can_sub))
			begin
				running_q <= 1'b0;
				done_q    <= 1'b1;
				ov_q      <= div_zero;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (i_md.req)
		begin
			quot_q <= '0;
			rem_q  <= i_md.a;
		end
		else if (running_q)
		begin
			// Zero divisor clears the remainder, quotient is still 0
			if (div_zero)
				rem_q <= '0;
			else if (can_sub)
			begin
				rem_q  <= rem_q - i_md.b;
				quot_q <= quot_q + 8'd1;
			end
		end
	end

	assign i_md.done = done_q;
	assign i_md.lo   = quot_q;
	assign i_md.hi   = rem_q;
	assign i_md.ov   = ov_q;

endmodule

// ==== rtl/alu_sequencer.sv ====
/*
 * Operand latch, dispatch and result stage of the ALU.
 * A start while busy is dropped; results hold until the next o_ready.
 * Single-cycle opcodes raise o_ready one clock after the accepting edge.
 */
`timescale 1ns/1ps
module alu_sequencer (
	input  logic                               clk,
	input  logic                               reset_n,
	input  logic                               i_start,
	input  alu8051_pkg::alu_op_e               i_op,
	input  alu8051_pkg::byte_t                 i_operand_a,
	input  alu8051_pkg::byte_t                 i_operand_b,
	input  alu8051_pkg::byte_t                 i_bit_addr,
	input  alu8051_pkg::byte_t                 i_bit_byte,
	input  alu8051_pkg::byte_t                 i_psw,
	input  alu8051_pkg::psw_mode_e             i_psw_mode,
	output alu8051_pkg::alu_op_e               o_op,
	output alu8051_pkg::byte_t                 o_a,
	output alu8051_pkg::byte_t                 o_b,
	output alu8051_pkg::byte_t                 o_bit_byte,
	output logic [alu8051_pkg::BIT_IDX_W-1:0]  o_bit_idx,
	output logic                               o_cy,
	output logic                               o_ac,
	input  alu8051_pkg::byte_t                 i_lo,
	input  alu8051_pkg::byte_t                 i_hi,
	input  logic                               i_cy,
	input  logic                               i_ac,
	input  logic                               i_ov,
	muldiv_if.requester                        o_mul,
	muldiv_if.requester                        o_div,
	output alu8051_pkg::byte_t                 o_result_lo,
	output alu8051_pkg::byte_t                 o_result_hi,
	output alu8051_pkg::byte_t                 o_psw,
	output logic                               o_ready,
	output logic                               o_busy
);
	import alu8051_pkg::*;

	alu_op_e              op_q;
	byte_t                a_q;
	byte_t                b_q;
	byte_t                bit_byte_q;
	logic [BIT_IDX_W-1:0] bit_idx_q;
	byte_t                psw_q;
	psw_mode_e            mode_q;
	logic                 exec_q;
	logic                 wait_q;
	logic                 mul_req_q;
	logic                 div_req_q;
	logic                 accept;
	logic                 is_muldiv;
	logic                 use_mul;
	logic                 finish;
	byte_t                res_lo;
	byte_t                res_hi;
	logic                 new_cy;
	logic                 new_ac;
	logic                 new_ov;
	byte_t                psw_new;

	assign accept    = i_start && !o_busy;
	assign is_muldiv = (i_op == OP_MUL) || (i_op == OP_DIV);
	assign use_mul   = (op_q == OP_MUL);
	assign finish    = exec_q || (wait_q && (use_mul ? o_mul.done : o_div.done));
	assign o_busy    = exec_q || wait_q;

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			op_q       <= i_op;
			a_q        <= i_operand_a;
			b_q        <= i_operand_b;
			bit_byte_q <= i_bit_byte;
			bit_idx_q  <= i_bit_addr[BIT_IDX_W-1:0];
			psw_q      <= i_psw;
			mode_q     <= i_psw_mode;
		end
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			exec_q    <= 1'b0;
			wait_q    <= 1'b0;
			mul_req_q <= 1'b0;
			div_req_q <= 1'b0;
		end
		else
		begin
			mul_req_q <= accept && (i_op == OP_MUL);
			div_req_q <= accept && (i_op == OP_DIV);
			if (accept)
			begin
				exec_q <= !is_muldiv;
				wait_q <= is_muldiv;
			end
			else if (finish)
			begin
				exec_q <= 1'b0;
				wait_q <= 1'b0;
			end
		end
	end

	// Result select and PSW merge
	always_comb
	begin
		if (wait_q)
		begin
			res_lo = use_mul ? o_mul.lo : o_div.lo;
			res_hi = use_mul ? o_mul.hi : o_div.hi;
			new_cy = 1'b0;
			new_ac = psw_q[PSW_AC];
			new_ov = use_mul ? o_mul.ov : o_div.ov;
		end
		else
		begin
			res_lo = i_lo;
			res_hi = i_hi;
			new_cy = i_cy;
			new_ac = i_ac;
			new_ov = i_ov;
		end
		// Reserved bit stays 0
		psw_new          = '0;
		psw_new[PSW_CY]  = new_cy;
		psw_new[PSW_AC]  = new_ac;
		psw_new[PSW_F0]  = psw_q[PSW_F0];
		psw_new[PSW_RS1] = psw_q[PSW_RS1];
		psw_new[PSW_RS0] = psw_q[PSW_RS0];
		psw_new[PSW_OV]  = new_ov;
		psw_new[PSW_P]   = ^a_q;
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			o_result_lo <= '0;
			o_result_hi <= '0;
			o_psw       <= '0;
			o_ready     <= 1'b0;
		end
		else
		begin
			o_ready <= finish;
			if (finish)
			begin
				o_result_lo <= res_lo;
				o_result_hi <= res_hi;
				o_psw       <= (mode_q == PSW_RELOAD) ? psw_q : psw_new;
			end
		end
	end

	assign o_op       = op_q;
	assign o_a        = a_q;
	assign o_b        = b_q;
	assign o_bit_byte = bit_byte_q;
	assign o_bit_idx  = bit_idx_q;
	assign o_cy       = psw_q[PSW_CY];
	assign o_ac       = psw_q[PSW_AC];

	assign o_mul.req = mul_req_q;
	assign o_mul.a   = a_q;
	assign o_mul.b   = b_q;
	assign o_div.req = div_req_q;
	assign o_div.a   = a_q;
	assign o_div.b   = b_q;

endmodule

// ==== rtl/alu8051_top.sv ====
/*
 * 8051-class ALU top level with a start/ready handshake.
 * MUL and DIV take several cycles, watch o_busy before the next start.
 */
`timescale 1ns/1ps
module alu8051_top (
	input  logic                   clk,
	input  logic                   reset_n,
	input  logic                   i_start,
	input  alu8051_pkg::alu_op_e   i_op,
	input  alu8051_pkg::byte_t     i_operand_a,
	input  alu8051_pkg::byte_t     i_operand_b,
	input  alu8051_pkg::byte_t     i_bit_addr,
	input  alu8051_pkg::byte_t     i_bit_byte,
	input  alu8051_pkg::byte_t     i_psw,
	input  alu8051_pkg::psw_mode_e i_psw_mode,
	output alu8051_pkg::byte_t     o_result_lo,
	output alu8051_pkg::byte_t     o_result_hi,
	output alu8051_pkg::byte_t     o_psw,
	output logic                   o_ready,
	output logic                   o_busy
);
	import alu8051_pkg::*;

	alu_op_e              combo_op;
	byte_t                combo_a;
	byte_t                combo_b;
	byte_t                combo_bit_byte;
	logic [BIT_IDX_W-1:0] combo_bit_idx;
	logic                 combo_cy_in;
	logic                 combo_ac_in;
	byte_t                combo_lo;
	byte_t                combo_hi;
	logic                 combo_cy;
	logic                 combo_ac;
	logic                 combo_ov;

	muldiv_if mul_if ();
	muldiv_if div_if ();

	alu_sequencer u_sequencer (
		.clk         (clk),
		.reset_n     (reset_n),
		.i_start     (i_start),
		.i_op        (i_op),
		.i_operand_a (i_operand_a),
		.i_operand_b (i_operand_b),
		.i_bit_addr  (i_bit_addr),
		.i_bit_byte  (i_bit_byte),
		.i_psw       (i_psw),
		.i_psw_mode  (i_psw_mode),
		.o_op        (combo_op),
		.o_a         (combo_a),
		.o_b         (combo_b),
		.o_bit_byte  (combo_bit_byte),
		.o_bit_idx   (combo_bit_idx),
		.o_cy        (combo_cy_in),
		.o_ac        (combo_ac_in),
		.i_lo        (combo_lo),
		.i_hi        (combo_hi),
		.i_cy        (combo_cy),
		.i_ac        (combo_ac),
		.i_ov        (combo_ov),
		.o_mul       (mul_if.requester),
		.o_div       (div_if.requester),
		.o_result_lo (o_result_lo),
		.o_result_hi (o_result_hi),
		.o_psw       (o_psw),
		.o_ready     (o_ready),
		.o_busy      (o_busy)
	);

	alu_combo_unit u_combo (
		.i_op       (combo_op),
		.i_a        (combo_a),
		.i_b        (combo_b),
		.i_bit_byte (combo_bit_byte),
		.i_bit_idx  (combo_bit_idx),
		.i_cy       (combo_cy_in),
		.i_ac       (combo_ac_in),
		.o_lo       (combo_lo),
		.o_hi       (combo_hi),
		.o_cy       (combo_cy),
		.o_ac       (combo_ac),
		.o_ov       (combo_ov)
	);

	alu_multiplier u_mul (
		.clk     (clk),
		.reset_n (reset_n),
		.i_md    (mul_if.unit)
	);

	alu_divider u_div (
		.clk     (clk),
		.reset_n (reset_n),
		.i_md    (div_if.unit)
	);

endmodule

// ==== tests/alu8051_assertions.sv ====
/*
 * Handshake checks bound into alu8051_top.
 * The failures counter is read by the testbench at the end of the run.
 */
`timescale 1ns/1ps
module alu8051_assertions (
	input logic                 clk,
	input logic                 reset_n,
	input logic                 i_start,
	input alu8051_pkg::alu_op_e i_op,
	input logic                 o_ready,
	input logic                 o_busy
);
	import alu8051_pkg::*;

	int   failures;
	logic single_start;

	initial
		failures = 0;

	// Accepted start of an opcode that bypasses MUL and DIV
	assign single_start = i_start && !o_busy && (i_op != OP_MUL) && (i_op != OP_DIV);

	ready_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
		o_ready |=> !o_ready)
	else
	begin
		$error("o_ready stayed high for more than one cycle");
		failures++;
	end

	ready_after_busy: assert property (@(posedge clk) disable iff (!reset_n)
		o_ready |-> $past(o_busy))
	else
	begin
		$error("o_ready without o_busy in the cycle before");
		failures++;
	end

	single_latency: assert property (@(posedge clk) disable iff (!reset_n)
		single_start |-> ##2 o_ready)
	else
	begin
		$error("single-cycle opcode did not finish with the expected latency");
		failures++;
	end

endmodule

bind alu8051_top alu8051_assertions u_assertions (
	.clk     (clk),
	.reset_n (reset_n),
	.i_start (i_start),
	.i_op    (i_op),
	.o_ready (o_ready),
	.o_busy  (o_busy)
);

// ==== tests/alu8051_tb.sv ====
/*
 * Testbench for alu8051_top, one operation in flight at a time.
 * Expected values come from ref_alu and are queued per accepted start.
 * Outputs are sampled on the falling clock edge.
 */
`timescale 1ns/1ps
module alu8051_tb;
	import alu8051_pkg::*;

	localparam int TIMEOUT_CYCLES = 400;
	localparam logic [31:0] RAND_SEED = 32'hb300_9aa3;

	typedef struct packed {
		alu_op_e op;
		byte_t   lo;
		byte_t   hi;
		byte_t   psw;
	} exp_t;

	logic      clk;
	logic      reset_n;
	logic      i_start;
	alu_op_e   i_op;
	byte_t     i_operand_a;
	byte_t     i_operand_b;
	byte_t     i_bit_addr;
	byte_t     i_bit_byte;
	byte_t     i_psw;
	psw_mode_e i_psw_mode;
	byte_t     o_result_lo;
	byte_t     o_result_hi;
	byte_t     o_psw;
	logic      o_ready;
	logic      o_busy;

	exp_t pending[$];
	int   results_seen = 0;
	int   checks = 0;
	int   errors = 0;
	int   tests_done = 0;

	alu_op_e arith_ops[] = '{OP_ADD, OP_ADDC, OP_SUBB};
	alu_op_e word_ops[] = '{OP_RR, OP_RL, OP_RRC, OP_RLC, OP_AND, OP_OR, OP_XOR, OP_CPL,
		OP_SWAP, OP_DA, OP_XCHD, OP_INCDPTR, OP_CJNE};
	alu_op_e bit_ops[] = '{OP_ANLC, OP_ANLNC, OP_ORLC, OP_ORLNC, OP_MOVCB, OP_CLRC,
		OP_SETBC, OP_CPLC, OP_CLRB, OP_SETBB, OP_CPLB, OP_MOVBC};

	alu8051_top DUT (.*);

	always #4 clk = ~clk;

	// Expected lo, hi and PSW of one operation
	function automatic exp_t ref_alu(alu_op_e op, byte_t a, byte_t b, byte_t bit_addr,
		byte_t bit_byte, byte_t psw, psw_mode_e mode);
		exp_t  r;
		logic  cy;
		logic  ac;
		logic  ov;
		logic  cin;
		logic  bv;
		byte_t bb;
		byte_t mask;
		int    s;
		int    adj;
		cy = psw[PSW_CY];
		ac = psw[PSW_AC];
		ov = 1'b0;
		r.op = op;
		r.lo = a;
		r.hi = 8'h00;
		mask = 8'h01 << (bit_addr % 8);
		bv = (bit_byte & mask) != 0;
		bb = (op == OP_SUBB) ? byte_t'(256 - int'(b)) : b;
		cin = (op == OP_ADDC) && psw[PSW_CY];
		case (op)
			OP_ADD, OP_ADDC, OP_SUBB:
			begin
				s = int'(a) + int'(bb) + int'(cin);
				r.lo = s[7:0];
				cy = s > 255;
				ac = (int'(a % 16) + int'(bb % 16) + int'(cin)) > 15;
				ov = cy ^ ((int'(a % 128) + int'(bb % 128) + int'(cin)) > 127);
			end
			OP_RR:   r.lo = (a >> 1) | (a << 7);
			OP_RL:   r.lo = (a << 1) | (a >> 7);
			OP_RRC:
			begin
				r.lo = (a >> 1) | (psw[PSW_CY] ? 8'h80 : 8'h00);
				cy = a[0];
			end
			OP_RLC:
			begin
				r.lo = (a << 1) | (psw[PSW_CY] ? 8'h01 : 8'h00);
				cy = a[7];
			end
			OP_AND:  r.lo = a & b;
			OP_OR:   r.lo = a | b;
			OP_XOR:  r.lo = a ^ b;
			OP_CPL:  r.lo = ~a;
			OP_SWAP: r.lo = (a << 4) | (a >> 4);
			OP_DA:
			begin
				adj = 0;
				if ((a % 16) > 9 || ac)
					adj += 'h06;
				if ((a / 16) > 9 || cy)
					adj += 'h60;
				s = int'(a) + adj;
				r.lo = s[7:0];
				if (s > 255)
					cy = 1'b1;
			end
			OP_XCHD:
			begin
				r.lo = (a & 8'hf0) | (b & 8'h0f);
				r.hi = (b & 8'hf0) | (a & 8'h0f);
			end
			OP_INCDPTR:
			begin
				s = int'(b) * 256 + int'(a) + 1;
				r.lo = s[7:0];
				r.hi = s[15:8];
			end
			OP_MUL:
			begin
				s = int'(a) * int'(b);
				r.lo = s[7:0];
				r.hi = s[15:8];
				cy = 1'b0;
				ov = s > 255;
			end
			OP_DIV:
			begin
				r.lo = (b == 0) ? 8'h00 : a / b;
				r.hi = (b == 0) ? 8'h00 : a % b;
				cy = 1'b0;
				ov = (b == 0);
			end
			OP_ANLC:  cy = cy && bv;
			OP_ANLNC: cy = cy && !bv;
			OP_ORLC:  cy = cy || bv;
			OP_ORLNC: cy = cy || !bv;
			OP_MOVCB: cy = bv;
			OP_CLRC:  cy = 1'b0;
			OP_SETBC: cy = 1'b1;
			OP_CPLC:  cy = !cy;
			OP_CJNE:  cy = a < b;
			OP_CLRB:  r.lo = bit_byte & ~mask;
			OP_SETBB: r.lo = bit_byte | mask;
			OP_CPLB:  r.lo = bit_byte ^ mask;
			OP_MOVBC: r.lo = psw[PSW_CY] ? (bit_byte | mask) : (bit_byte & ~mask);
			default: ;
		endcase
		if (mode == PSW_RELOAD)
			r.psw = psw;
		else
			r.psw = {cy, ac, psw[5:3], ov, 1'b0, ^a};
		return r;
	endfunction

	task automatic check_value(string sig, alu_op_e op, byte_t got, byte_t exp);
		checks++;
		if (got !== exp)
		begin
			$display("Fail %s: got %h expected %h (%s)", sig, got, exp, op.name());
			errors++;
		end
	endtask

	// Compare each o_ready against the oldest queued expectation
	always @(negedge clk)
	begin : compare
		exp_t e;
		if (reset_n && o_ready)
		begin
			if (pending.size() == 0)
			begin
				$display("o_ready pulsed with no operation pending");
				errors++;
			end
			else
			begin
				e = pending.pop_front();
				check_value("o_result_lo", e.op, o_result_lo, e.lo);
				check_value("o_result_hi", e.op, o_result_hi, e.hi);
				check_value("o_psw", e.op, o_psw, e.psw);
				results_seen++;
			end
		end
	end

	task automatic end_run();
		int total;
		total = errors + DUT.u_assertions.failures;
		$display("Summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
			tests_done, checks, errors, DUT.u_assertions.failures);
		if (total == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	endtask

	task automatic wait_result(int target);
		int cycles;
		cycles = 0;
		while (results_seen < target && cycles < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycles++;
		end
		if (results_seen < target)
		begin
			$display("Timeout: no o_ready within %0d cycles of the start", TIMEOUT_CYCLES);
			errors++;
			end_run();
		end
	endtask

	task automatic drive_start(alu_op_e op, byte_t a, byte_t b, byte_t bit_addr,
		byte_t bit_byte, byte_t psw, psw_mode_e mode);
		@(posedge clk);
		#1;
		i_op        = op;
		i_operand_a = a;
		i_operand_b = b;
		i_bit_addr  = bit_addr;
		i_bit_byte  = bit_byte;
		i_psw       = psw;
		i_psw_mode  = mode;
		i_start     = 1'b1;
		@(posedge clk);
		#1;
		i_start = 1'b0;
	endtask

	task automatic run_op(alu_op_e op, byte_t a, byte_t b, byte_t bit_addr,
		byte_t bit_byte, byte_t psw, psw_mode_e mode);
		int target;
		target = results_seen + 1;
		pending.push_back(ref_alu(op, a, b, bit_addr, bit_byte, psw, mode));
		drive_start(op, a, b, bit_addr, bit_byte, psw, mode);
		wait_result(target);
	endtask

	// Operands drawn one by one so the sequence is fixed by the seed
	task automatic run_random(alu_op_e op, psw_mode_e mode);
		byte_t a;
		byte_t b;
		byte_t bit_addr;
		byte_t bit_byte;
		byte_t psw;
		a        = byte_t'($urandom);
		b        = byte_t'($urandom);
		bit_addr = byte_t'($urandom);
		bit_byte = byte_t'($urandom);
		psw      = byte_t'($urandom);
		run_op(op, a, b, bit_addr, bit_byte, psw, mode);
	endtask

	task automatic report_test(string name, int ops, int err_before);
		tests_done++;
		$display("Test %s finished: %0d operations, %0d errors", name, ops,
			errors - err_before);
	endtask

	// Second start lands while the MUL is still running
	task automatic busy_start_test();
		byte_t a;
		byte_t b;
		int    target;
		a = byte_t'($urandom);
		b = byte_t'($urandom);
		target = results_seen + 1;
		pending.push_back(ref_alu(OP_MUL, a, b, 8'h00, 8'h00, 8'h00, PSW_UPDATE));
		drive_start(OP_MUL, a, b, 8'h00, 8'h00, 8'h00, PSW_UPDATE);
		drive_start(OP_ADD, ~a, ~b, 8'h00, 8'h00, 8'hff, PSW_UPDATE);
		if (!o_busy)
		begin
			$display("o_busy was low while the MUL should still be running");
			errors++;
		end
		wait_result(target);
		repeat (20) @(posedge clk);
	endtask

	initial
	begin
		int err0;
		void'($urandom(RAND_SEED));
		clk         = 1'b0;
		reset_n     = 1'b0;
		i_start     = 1'b0;
		i_op        = OP_IDLE;
		i_operand_a = 8'h00;
		i_operand_b = 8'h00;
		i_bit_addr  = 8'h00;
		i_bit_byte  = 8'h00;
		i_psw       = 8'h00;
		i_psw_mode  = PSW_UPDATE;
		repeat (10) @(posedge clk);
		#1;
		reset_n = 1'b1;

		err0 = errors;
		for (int i = 0; i < 90; i++)
			run_random(arith_ops[i % 3], PSW_UPDATE);
		report_test("add_addc_subb", 90, err0);

		err0 = errors;
		foreach (word_ops[k])
			for (int i = 0; i < 8; i++)
				run_random(word_ops[k], PSW_UPDATE);
		report_test("byte_ops", 8 * word_ops.size(), err0);

		err0 = errors;
		foreach (bit_ops[k])
			for (int i = 0; i < 8; i++)
				run_random(bit_ops[k], PSW_UPDATE);
		report_test("bit_ops", 8 * bit_ops.size(), err0);

		err0 = errors;
		for (int i = 0; i < 20; i++)
			run_random((i % 2) ? OP_DIV : OP_MUL, PSW_UPDATE);
		run_op(OP_DIV, 8'h5a, 8'h00, 8'h00, 8'h00, 8'hc7, PSW_UPDATE);
		run_op(OP_DIV, 8'hff, 8'h01, 8'h00, 8'h00, 8'h41, PSW_UPDATE);
		run_op(OP_MUL, 8'hff, 8'hff, 8'h00, 8'h00, 8'h80, PSW_UPDATE);
		run_op(OP_MUL, 8'h0f, 8'h11, 8'h00, 8'h00, 8'hff, PSW_UPDATE);
		report_test("mul_div", 24, err0);

		err0 = errors;
		for (int k = 0; k <= int'(OP_MOVBC); k++)
			run_random(alu_op_e'(k), PSW_RELOAD);
		report_test("psw_reload", int'(OP_MOVBC) + 1, err0);

		err0 = errors;
		busy_start_test();
		report_test("start_while_busy", 1, err0);

		end_run();
	end

endmodule

// ==== alu8051.f ====
rtl/alu8051_pkg.sv
rtl/muldiv_if.sv
rtl/alu_combo_unit.sv
rtl/alu_multiplier.sv
rtl/alu_divider.sv
rtl/alu_sequencer.sv
rtl/alu8051_top.sv
tests/alu8051_assertions.sv
tests/alu8051_tb.sv
